// ==== all.f ====
+incdir+logic
logic/neuron_pkg.sv
logic/fp_mult.sv
logic/fp_add.sv
logic/weight_bank.sv
logic/neuron_node.sv
logic/neuron_top.sv
tests/neuron_tb.sv

// ==== Makefile ====
TOP = neuron_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

# The run passes only when the pass message shows up in the output
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== tests/neuron_tb.sv ====
`timescale 1ns/1ps
`include "neuron_macros.svh"

module neuron_tb;
	import neuron_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int SUM_VECTORS = 16;
	localparam int NEG_VECTORS = 8;
	localparam int STREAM_VECTORS = 20;
	localparam int TOTAL_VECTORS = SUM_VECTORS + 2 * NEG_VECTORS + STREAM_VECTORS + 2;

	logic                          clk;
	logic                          rst_n;
	logic                          wr_en;
	logic [`BANK_AW-1:0]           wr_addr;
	logic [31:0]                   wr_data;
	logic                          in_valid;
	logic [`NODE_INPUTS-1:0][31:0] x;
	logic                          out_valid;
	float32_t                      y;

	// Testbench copy of the bank contents
	real         w_model [`NODE_INPUTS];
	int          w_idx [`NODE_INPUTS];
	real         b_model;
	bit          relu_model;
	int          cur_x [`NODE_INPUTS];
	int          neg_x [NEG_VECTORS][`NODE_INPUTS];
	logic [31:0] exp_q [$];
	logic [31:0] exp_head;
	bit          check_idle;
	string       cur_test;
	int          seed;
	int          error_count;
	int          errors_at_start;
	int          tests_passed;
	int          tests_failed;

	neuron_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.in_valid  (in_valid),
		.x         (x),
		.out_valid (out_valid),
		.y         (y)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog sized from the number of vectors plus a margin for writes and draining
	initial
	begin
		#((TOTAL_VECTORS + 100) * CLK_PERIOD);
		$display("Timeout: the run did not finish, stuck in test %s", cur_test);
		$display("Some tests failed");
		$finish;
	end

	// Head of the expected queue, refreshed away from the checking edge
	always @(negedge clk)
	begin
		if (exp_q.size() > 0)
			exp_head = exp_q[0];
		else
			exp_head = 32'd0;
	end

	always @(posedge clk)
	begin
		if (rst_n && out_valid && exp_q.size() > 0)
			void'(exp_q.pop_front());
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (y.bits == exp_head))
		else
		begin
			$display("Mismatch in %s: expected %h, actual %h", cur_test,
				$sampled(exp_head), $sampled(y.bits));
			error_count++;
		end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid))
		else
		begin
			$display("Error in %s: out_valid did not follow in_valid by one cycle", cur_test);
			error_count++;
		end

	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		check_idle |-> (!out_valid && y.bits == 32'd0))
		else
		begin
			$display("Mismatch in %s: expected out_valid 0 and y 00000000, actual %b and %h",
				cur_test, $sampled(out_valid), $sampled(y.bits));
			error_count++;
		end

	// Encodes an exactly representable real value as a single-precision word
	function automatic logic [31:0] real_to_float(real v);
		logic        sign;
		int          e;
		real         m;
		logic [22:0] frac;
		if (v == 0.0)
			return 32'd0;
		sign = (v < 0.0);
		m = sign ? -v : v;
		e = 127;
		while (m >= 2.0)
		begin
			m = m / 2.0;
			e++;
		end
		while (m < 1.0)
		begin
			m = m * 2.0;
			e--;
		end
		frac = 23'($rtoi((m - 1.0) * 8388608.0));
		return {sign, e[7:0], frac};
	endfunction

	function automatic real weight_value(int k);
		return 0.25 * real'(1 << k);
	endfunction

	function automatic real model_sum();
		real s;
		s = b_model;
		for (int i = 0; i < `NODE_INPUTS; i++)
			s = s + real'(cur_x[i]) * w_model[i];
		return s;
	endfunction

	function automatic logic [31:0] expected_word();
		real s;
		s = model_sum();
		if (relu_model && s < 0.0)
			return 32'd0;
		return real_to_float(s);
	endfunction

	task automatic write_reg(input int addr, input logic [31:0] data);
		@(negedge clk);
		in_valid = 1'b0;
		wr_en    = 1'b1;
		wr_addr  = `BANK_AW'(addr);
		wr_data  = data;
	endtask

	task automatic write_weight(input int i, input int k);
		write_reg(i, real_to_float(weight_value(k)));
		w_idx[i]   = k;
		w_model[i] = weight_value(k);
	endtask

	task automatic idle();
		@(negedge clk);
		wr_en    = 1'b0;
		in_valid = 1'b0;
	endtask

	// Draws random operands until the sum has the wanted sign
	task automatic pick_vector(input bit want_negative);
		do
		begin
			for (int i = 0; i < `NODE_INPUTS; i++)
				cur_x[i] = $random(seed) % 9;
		end
		while ((model_sum() < 0.0) != want_negative);
	endtask

	task automatic send_vector();
		@(negedge clk);
		wr_en    = 1'b0;
		in_valid = 1'b1;
		for (int i = 0; i < `NODE_INPUTS; i++)
			x[i] = real_to_float(real'(cur_x[i]));
		exp_q.push_back(expected_word());
	endtask

	task automatic drain();
		idle();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic start_test(input string name);
		cur_test        = name;
		errors_at_start = error_count;
	endtask

	task automatic finish_test();
		if (error_count == errors_at_start)
		begin
			tests_passed++;
			$display("Test %s: ok", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", cur_test, error_count - errors_at_start);
		end
	endtask

	initial
	begin
		int k;
		seed = 58;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		in_valid = 1'b0;
		x = '0;
		check_idle = 1'b0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_test = "reset";
		b_model = 0.0;
		relu_model = 1'b1;
		for (int i = 0; i < `NODE_INPUTS; i++)
		begin
			w_model[i] = 0.0;
			w_idx[i] = 0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset_state");
		check_idle = 1'b1;
		repeat (10) @(negedge clk);
		check_idle = 1'b0;
		finish_test();

		start_test("weighted_sum");
		for (int i = 0; i < `NODE_INPUTS; i++)
		begin
			k = $random(seed) % 5;
			write_weight(i, (k < 0) ? -k : k);
		end
		k = $random(seed) % 5;
		write_reg(`ADDR_BIAS, real_to_float(real'(k)));
		b_model = real'(k);
		for (int v = 0; v < SUM_VECTORS; v++)
		begin
			pick_vector(1'b0);
			send_vector();
		end
		drain();
		finish_test();

		start_test("clamp");
		for (int v = 0; v < NEG_VECTORS; v++)
		begin
			pick_vector(1'b1);
			neg_x[v] = cur_x;
			send_vector();
		end
		drain();
		finish_test();

		start_test("clamp_disabled");
		write_reg(`ADDR_CTRL, 32'd0);
		relu_model = 1'b0;
		for (int v = 0; v < NEG_VECTORS; v++)
		begin
			cur_x = neg_x[v];
			send_vector();
		end
		drain();
		finish_test();

		start_test("streaming");
		for (int v = 0; v < STREAM_VECTORS; v++)
		begin
			for (int i = 0; i < `NODE_INPUTS; i++)
				cur_x[i] = $random(seed) % 9;
			send_vector();
		end
		drain();
		finish_test();

		// The weight write lands on the edge that samples the first vector
		start_test("weight_rewrite");
		for (int i = 0; i < `NODE_INPUTS; i++)
			cur_x[i] = $random(seed) % 9;
		cur_x[0] = 3;
		send_vector();
		k = (w_idx[0] + 2) % 5;
		wr_en   = 1'b1;
		wr_addr = '0;
		wr_data = real_to_float(weight_value(k));
		w_idx[0]   = k;
		w_model[0] = weight_value(k);
		send_vector();
		drain();
		finish_test();

		$display("Summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== logic/neuron_top.sv ====
`timescale 1ns/1ps
`include "neuron_macros.svh"

module neuron_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr_en,
	input  logic [`BANK_AW-1:0]           wr_addr,
	input  logic [31:0]                   wr_data,
	input  logic                          in_valid,
	input  logic [`NODE_INPUTS-1:0][31:0] x,
	output logic                          out_valid,
	output neuron_pkg::float32_t          y
);
	import neuron_pkg::*;

	logic [`NODE_INPUTS-1:0][31:0] weights;
	float32_t                      bias;
	logic                          relu_en;

	weight_bank bank_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.weights (weights),
		.bias    (bias),
		.relu_en (relu_en)
	);

	neuron_node node_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.x         (x),
		.weights   (weights),
		.bias      (bias),
		.relu_en   (relu_en),
		.out_valid (out_valid),
		.y         (y)
	);

endmodule

// ==== logic/neuron_node.sv ====
`timescale 1ns/1ps
`include "neuron_macros.svh"

module neuron_node (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic [`NODE_INPUTS-1:0][31:0] x,
	input  logic [`NODE_INPUTS-1:0][31:0] weights,
	input  neuron_pkg::float32_t          bias,
	input  logic                          relu_en,
	output logic                          out_valid,
	output neuron_pkg::float32_t          y
);
	import neuron_pkg::*;

	// Heap-ordered adder tree: node j sums nodes 2j+1 and 2j+2.
	// Leaves NODE_INPUTS..2*NODE_INPUTS-1 hold the products, the last leaf the bias
	float32_t tree [0:2*`NODE_INPUTS];
	float32_t result;

	for (genvar i = 0; i < `NODE_INPUTS; i++)
	begin : g_mult
		fp_mult mult_i (
			.a(x[i]),
			.b(weights[i]),
			.p(tree[`NODE_INPUTS + i])
		);
	end

	assign tree[2*`NODE_INPUTS] = bias;

	for (genvar j = 0; j < `NODE_INPUTS; j++)
	begin : g_add
		fp_add add_i (
			.a(tree[2*j + 1]),
			.b(tree[2*j + 2]),
			.s(tree[j])
		);
	end

	// Negative sums read as zero when the clamp is on
	assign result = (relu_en && tree[0].fields.sign) ? '0 : tree[0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			y         <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
				y <= result;
		end
	end

	a_out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid))
		else $error("out_valid is unknown after reset");

endmodule

// ==== logic/weight_bank.sv ====
`timescale 1ns/1ps
`include "neuron_macros.svh"

module weight_bank (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr_en,
	input  logic [`BANK_AW-1:0]           wr_addr,
	input  logic [31:0]                   wr_data,
	output logic [`NODE_INPUTS-1:0][31:0] weights,
	output neuron_pkg::float32_t          bias,
	output logic                          relu_en
);

	// The clamp comes out of reset enabled, as in the fixed node it replaces
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			weights <= '0;
			bias    <= '0;
			relu_en <= 1'b1;
		end
		else if (wr_en)
		begin
			for (int i = 0; i < `NODE_INPUTS; i++)
			begin
				if (wr_addr == `BANK_AW'(i))
					weights[i] <= wr_data;
			end
			if (wr_addr == `BANK_AW'(`ADDR_BIAS))
				bias <= wr_data;
			if (wr_addr == `BANK_AW'(`ADDR_CTRL))
				relu_en <= wr_data[`RELU_EN_BIT];
		end
	end

	// Nothing is mapped above the control register
	a_wr_addr_legal: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_addr <= `BANK_AW'(`ADDR_CTRL)))
		else $error("Write to unmapped bank address %0d", wr_addr);

endmodule

// ==== logic/fp_add.sv ====
`timescale 1ns/1ps

module fp_add (
	input  neuron_pkg::float32_t a,
	input  neuron_pkg::float32_t b,
	output neuron_pkg::float32_t s
);
	import neuron_pkg::*;

	float32_t          big_op;
	float32_t          small_op;
	logic              eff_sub;
	logic [7:0]        exp_diff;
	logic [26:0]       big_m;
	logic [26:0]       small_m;
	logic [26:0]       small_al;
	logic [27:0]       sum_m;
	logic [27:0]       norm_m;
	logic [4:0]        lz;
	logic              lz_found;
	logic signed [9:0] exp_res;

	// Magnitude order follows from comparing the words without the sign
	always_comb
	begin
		if (a.bits[30:0] >= b.bits[30:0])
		begin
			big_op   = a;
			small_op = b;
		end
		else
		begin
			big_op   = b;
			small_op = a;
		end
	end

	assign eff_sub  = a.fields.sign ^ b.fields.sign;
	assign exp_diff = big_op.fields.exponent - small_op.fields.exponent;

	// Restore the hidden bit and keep three extra low bits for the subtract case
	assign big_m = (big_op.fields.exponent != 8'd0) ?
		{1'b1, big_op.fields.mantissa, 3'b000} : 27'd0;
	assign small_m = (small_op.fields.exponent != 8'd0) ?
		{1'b1, small_op.fields.mantissa, 3'b000} : 27'd0;

	assign small_al = small_m >> exp_diff;

	assign sum_m = eff_sub ? ({1'b0, big_m} - {1'b0, small_al})
		: ({1'b0, big_m} + {1'b0, small_al});

	// Leading zeros are counted over the full sum with bit 27 as the carry position
	always_comb
	begin
		lz       = 5'd0;
		lz_found = 1'b0;
		for (int i = 27; i >= 0; i--)
		begin
			if (!lz_found)
			begin
				if (sum_m[i])
					lz_found = 1'b1;
				else
					lz = lz + 5'd1;
			end
		end
	end

	assign norm_m = sum_m << lz;

	// A carry (no leading zero) bumps the exponent by one
	assign exp_res = $signed({2'b00, big_op.fields.exponent}) + 10'sd1
		- $signed({5'd0, lz});

	always_comb
	begin
		if (sum_m == 28'd0)
		begin
			s.bits = 32'd0;
		end
		else if (exp_res <= 10'sd0)
		begin
			s.bits = {big_op.fields.sign, 31'd0};
		end
		else if (exp_res >= 10'sd255)
		begin
			s.bits = {big_op.fields.sign, 8'hfe, 23'h7fffff};
		end
		else
		begin
			s.bits = {big_op.fields.sign, exp_res[7:0], norm_m[26:4]};
		end
	end

endmodule

// ==== logic/fp_mult.sv ====
`timescale 1ns/1ps

module fp_mult (
	input  neuron_pkg::float32_t a,
	input  neuron_pkg::float32_t b,
	output neuron_pkg::float32_t p
);

	logic              zero_in;
	logic              sign_res;
	logic [47:0]       prod;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_res;
	logic [22:0]       mant_res;

	// Denormals count as zero, so only the exponent field matters here
	assign zero_in  = (a.fields.exponent == 8'd0) || (b.fields.exponent == 8'd0);
	assign sign_res = a.fields.sign ^ b.fields.sign;

	assign prod = {1'b1, a.fields.mantissa} * {1'b1, b.fields.mantissa};

	assign exp_sum = $signed({2'b00, a.fields.exponent})
		+ $signed({2'b00, b.fields.exponent})
		- 10'sd127;

	// The product of two values in [1,2) lies in [1,4), so at most one shift
	always_comb
	begin
		if (prod[47])
		begin
			exp_res  = exp_sum + 10'sd1;
			mant_res = prod[46:24];
		end
		else
		begin
			exp_res  = exp_sum;
			mant_res = prod[45:23];
		end
	end

	always_comb
	begin
		if (zero_in || exp_res <= 10'sd0)
		begin
			p.bits = {sign_res, 31'd0};
		end
		else if (exp_res >= 10'sd255)
		begin
			// Largest finite magnitude
			p.bits = {sign_res, 8'hfe, 23'h7fffff};
		end
		else
		begin
			p.bits = {sign_res, exp_res[7:0], mant_res};
		end
	end

endmodule

// ==== logic/neuron_pkg.sv ====
package neuron_pkg;

	// One single-precision word, taken either as raw bits or split into its fields
	typedef union packed {
		logic [31:0] bits;
		struct packed {
			logic        sign;
			logic [7:0]  exponent;
			logic [22:0] mantissa;
		} fields;
	} float32_t;

endpackage

// ==== logic/neuron_macros.svh ====
`ifndef NEURON_MACROS_SVH
`define NEURON_MACROS_SVH

// Number of weighted inputs into the node
`define NODE_INPUTS 4

// Bank address width, wide enough for the weights, bias and control register
`define BANK_AW 4

// The bias sits right after the last weight, the control word after the bias
`define ADDR_BIAS (`NODE_INPUTS)
`define ADDR_CTRL (`NODE_INPUTS + 1)

// Bit of the control register that enables the negative clamp
`define RELU_EN_BIT 0

`endif
